//--- hdl/cx4_pkg.sv
package cx4_pkg;

  //////////////////////////////////////////////////
  // widths and basic types
  //////////////////////////////////////////////////
  localparam int WORD_W    = 24;
  localparam int GPR_COUNT = 16;

  typedef logic [WORD_W-1:0] cx4_word_t;
  typedef logic [15:0]       cx4_instr_t;
  typedef logic [3:0]        cx4_gpr_idx_t;
  typedef logic [4:0]        cx4_alu_fn_t;   // opcode bits 15..11

  typedef enum logic [3:0] {
    OP_NOP, OP_JP, OP_SKIP,
    OP_LD, OP_ST, OP_ALU,
    OP_CMP, OP_SEX, OP_HLT
  } cx4_op_e;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
  } cx4_flags_t;

  // constant operand table, selected by 0x5x
  localparam cx4_word_t CX4_CONST [16] = '{
    24'h000000, 24'hffffff, 24'h00ff00, 24'hff0000,
    24'h00ffff, 24'hffff00, 24'h800000, 24'h7fffff,
    24'h008000, 24'h007fff, 24'hff7fff, 24'hffff7f,
    24'h010000, 24'hfeffff, 24'h000100, 24'h00feff
  };

  //////////////////////////////////////////////////
  // host register window
  //////////////////////////////////////////////////
  localparam logic [12:0] PGM_BASE     = 13'h0000;
  localparam logic [12:0] MMIO_PC_ADDR = 13'h1f4f;
  localparam logic [12:0] STATUS_BASE  = 13'h1f53;  // up to 0x1f5f
  localparam logic [12:0] GPR_BASE     = 13'h1f80;  // mirrored at 0x1fc0

  // operand select codes in the param byte
  localparam logic [7:0] SEL_A     = 8'h00;
  localparam logic [7:0] SEL_CONST = 8'h50;  // low nibble is the index
  localparam logic [7:0] SEL_GPR   = 8'h60;  // low nibble is the index

endpackage

//--- hdl/cx4_op_if.sv
`timescale 1ns/100ps

interface cx4_op_if import cx4_pkg::*; ();

  logic        op_valid;  // pulse in phase 0
  cx4_op_e     op;
  cx4_alu_fn_t fn;
  logic        imm;
  logic [1:0]  sa;        // accumulator pre-shift
  logic [7:0]  param;
  logic [3:0]  sub;       // opcode bits 11..8

  modport decode (
    output op_valid, op, fn, imm, sa, param, sub
  );

  modport execute (
    input op_valid, op, fn, imm, sa, param, sub
  );

endinterface

//--- hdl/cx4_wb_if.sv
`timescale 1ns/100ps

interface cx4_wb_if import cx4_pkg::*; ();

  logic         a_we;
  cx4_word_t    a_data;
  logic         flags_we;
  cx4_flags_t   flags;
  logic         gpr_we;
  cx4_gpr_idx_t gpr_idx;
  cx4_word_t    gpr_data;

  modport execute (output a_we, a_data, flags_we, flags, gpr_we, gpr_idx, gpr_data);

  modport result (input a_we, a_data, flags_we, flags, gpr_we, gpr_idx, gpr_data);

endinterface

//--- hdl/cx4_host_regs.sv
`timescale 1ns/100ps

module cx4_host_regs import cx4_pkg::*; (
  input  logic        CLK,
  input  logic        arst_n,
  input  logic        CS,
  input  logic [12:0] ADDR,
  input  logic [7:0]  DI,
  input  logic        reg_we_rising,
  input  logic        halt,
  input  logic [7:0]  gpr_rd_byte,
  output logic [7:0]  DO,
  output logic        go,
  output logic [7:0]  start_pc,
  output logic        cx4_active,
  output logic        pgm_we,
  output logic        gpr_host_we
);

  logic       pgm_sel;
  logic       pc_sel;
  logic       status_sel;
  logic       gpr_sel;
  logic       pc_wr;
  logic [7:0] status_byte;

  //////////////////////////////////////////////////
  // window decode
  //////////////////////////////////////////////////
  // program window runs up to the register page, RAM wraps inside it
  assign pgm_sel    = CS && (ADDR[12:8] != MMIO_PC_ADDR[12:8]);
  assign pc_sel     = CS && (ADDR == MMIO_PC_ADDR);
  assign status_sel = CS && (ADDR[12:5] == STATUS_BASE[12:5])
                         && (ADDR[4:0] >= STATUS_BASE[4:0]);
  assign gpr_sel    = CS && (ADDR[12:7] == GPR_BASE[12:7])
                         && (ADDR[5:4] != 2'b11);  // bit 6 ignored, mirror

  assign pc_wr       = pc_sel && reg_we_rising;
  assign pgm_we      = pgm_sel && reg_we_rising;
  assign gpr_host_we = gpr_sel && reg_we_rising;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      start_pc   <= '0;
      go         <= 1'b0;
      cx4_active <= 1'b0;
    end else begin
      go <= pc_wr;                 // start request to the sequencer
      if (pc_wr) begin
        start_pc <= DI;
      end
      if (pc_wr) begin
        cx4_active <= 1'b1;        // set wins over halt
      end else if (halt) begin
        cx4_active <= 1'b0;
      end
    end
  end

  assign status_byte = {1'b0, cx4_active, 4'b0000, ~cx4_active, 1'b0};

  // read mux, program bytes fall through to zero
  always_comb begin
    if (status_sel) DO = status_byte;
    else if (pc_sel) DO = start_pc;
    else if (gpr_sel) DO = gpr_rd_byte;
    else DO = 8'h00;
  end

endmodule

//--- hdl/cx4_pgm_ram.sv
`timescale 1ns/100ps

module cx4_pgm_ram import cx4_pkg::*; #(
  parameter int PGM_AW = 8
) (
  input  logic              CLK,
  input  logic              we,
  input  logic [12:0]       waddr,   // host byte address
  input  logic [7:0]        wdata,
  input  logic [PGM_AW-1:0] raddr,   // word address
  output cx4_instr_t        rdata
);

  cx4_instr_t  mem [2**PGM_AW];
  logic [12:0] woff;

  assign woff = waddr - PGM_BASE;   // byte offset inside the window

  // host side, even byte is the low byte
  always_ff @(posedge CLK) begin
    if (we) begin
      if (woff[0]) mem[woff[PGM_AW:1]][15:8] <= wdata;
      else mem[woff[PGM_AW:1]][7:0] <= wdata;
    end
  end

  // cpu side, one cycle read latency
  always_ff @(posedge CLK) begin
    rdata <= mem[raddr];
  end

endmodule

//--- hdl/cx4_decode.sv
`timescale 1ns/100ps

module cx4_decode import cx4_pkg::*; #(
  parameter int PGM_AW = 8
) (
  input  logic              CLK,
  input  logic              arst_n,
  input  logic              go,
  input  logic [7:0]        start_pc,
  input  cx4_instr_t        instr,
  input  cx4_flags_t        flags,
  output logic [PGM_AW-1:0] pgm_raddr,
  output logic              halt,
  cx4_op_if.decode          op_if
);

  typedef enum logic [2:0] {
    ST_IDLE, ST_P0, ST_P1, ST_P2, ST_P3
  } phase_e;

  phase_e            state;
  logic [PGM_AW-1:0] pc;
  logic              jp_take;
  logic              skip_take;

  function automatic cx4_op_e classify(cx4_alu_fn_t fn);
    case (fn)
      5'b00001, 5'b00010: return OP_JP;
      5'b00100: return OP_SKIP;
      5'b01100: return OP_LD;
      5'b11100: return OP_ST;
      5'b01001, 5'b01010: return OP_CMP;
      5'b01011: return OP_SEX;
      5'b10000, 5'b10001, 5'b10010,
      5'b10101, 5'b10110, 5'b10111,
      5'b11000, 5'b11001, 5'b11010, 5'b11011: return OP_ALU;
      5'b11111: return OP_HLT;
      default: return OP_NOP;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // branch conditions
  //////////////////////////////////////////////////
  always_comb begin
    case (op_if.sub[3:2])
      2'b10: jp_take = 1'b1;
      2'b11: jp_take = flags.z;
      2'b00: jp_take = flags.c;
      default: jp_take = flags.n;
    endcase
    case (op_if.sub[1:0])
      2'b01: skip_take = (flags.c == op_if.param[0]);
      2'b10: skip_take = (flags.z == op_if.param[0]);
      2'b11: skip_take = (flags.n == op_if.param[0]);
      default: skip_take = 1'b0;
    endcase
  end

  assign pgm_raddr = pc;  // word lands in phase 3

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state       <= ST_IDLE;
      pc          <= '0;
      halt        <= 1'b0;
      op_if.op_valid <= 1'b0;
      op_if.op    <= OP_NOP;
      op_if.fn    <= '0;
      op_if.imm   <= 1'b0;
      op_if.sa    <= '0;
      op_if.param <= '0;
      op_if.sub   <= '0;
    end else begin
      op_if.op_valid <= 1'b0;
      halt           <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (go) begin
            pc       <= PGM_AW'(start_pc);
            state    <= ST_P2;  // first fetch without an op in flight
          end
        end
        ST_P0: begin
          if (op_if.op == OP_HLT) begin
            halt  <= 1'b1;
            state <= ST_IDLE;
          end else begin
            state <= ST_P1;
          end
        end
        ST_P1: begin
          state <= ST_P2;
          if (op_if.op == OP_JP && jp_take) pc <= PGM_AW'(op_if.param);
          else if (op_if.op == OP_SKIP && skip_take) pc <= pc + PGM_AW'(2);
          else pc <= pc + PGM_AW'(1);
        end
        ST_P2: state <= ST_P3;
        default: begin  // phase 3 latches the fetched word
          op_if.op       <= classify(instr[15:11]);
          op_if.fn       <= instr[15:11];
          op_if.sub      <= instr[11:8];
          op_if.imm      <= instr[10];
          op_if.sa       <= instr[9:8];
          op_if.param    <= instr[7:0];
          op_if.op_valid <= 1'b1;
          state          <= ST_P0;
        end
      endcase
    end
  end

endmodule

//--- hdl/cx4_execute.sv
`timescale 1ns/100ps

module cx4_execute import cx4_pkg::*; (
  input  logic         CLK,
  input  logic         arst_n,
  cx4_op_if.execute    op_if,
  input  cx4_word_t    acc,
  input  cx4_flags_t   flags,
  input  cx4_word_t    gpr_rd_data,
  output cx4_gpr_idx_t gpr_rd_idx,
  cx4_wb_if.execute    wb_if
);

  cx4_word_t   operand;
  cx4_word_t   shifted;
  cx4_word_t   idb_q;       // operand bus held for phase 1
  cx4_word_t   sa_q;        // pre-shifted A
  cx4_word_t   asr;
  cx4_word_t   rot;
  logic [24:0] sum;
  logic [24:0] dif_is;
  logic [24:0] dif_si;
  logic [24:0] res;         // bit 24 is carry or borrow
  cx4_flags_t  new_flags;
  logic        ph1;
  logic        a_wr;

  assign gpr_rd_idx = op_if.param[3:0];

  //////////////////////////////////////////////////
  // phase 0 operand and shifter
  //////////////////////////////////////////////////
  always_comb begin
    if (op_if.imm) operand = cx4_word_t'(op_if.param);
    else if (op_if.param == SEL_A) operand = acc;
    else if (op_if.param[7:4] == SEL_CONST[7:4]) operand = CX4_CONST[op_if.param[3:0]];
    else if (op_if.param[7:4] == SEL_GPR[7:4]) operand = gpr_rd_data;
    else operand = '0;
    case (op_if.sa)
      2'b00: shifted = acc;
      2'b01: shifted = acc << 1;
      2'b10: shifted = acc << 8;
      default: shifted = acc << 16;
    endcase
  end

  //////////////////////////////////////////////////
  // phase 1 ALU
  //////////////////////////////////////////////////
  assign sum    = {1'b0, sa_q} + {1'b0, idb_q};
  assign dif_is = {1'b0, idb_q} - {1'b0, sa_q};
  assign dif_si = {1'b0, sa_q} - {1'b0, idb_q};
  assign asr    = cx4_word_t'($signed(acc) >>> idb_q[4:0]);
  assign rot    = cx4_word_t'({acc, acc} >> idb_q[4:0]);  // rotate right

  always_comb begin
    res = {1'b0, idb_q};
    case (op_if.op)
      OP_CMP: res = (op_if.fn == 5'b01001) ? dif_is : dif_si;
      OP_SEX: begin
        if (op_if.sub[1:0] == 2'b01) res = {1'b0, {16{idb_q[7]}}, idb_q[7:0]};
        else if (op_if.sub[1:0] == 2'b10) res = {1'b0, {8{idb_q[15]}}, idb_q[15:0]};
      end
      OP_ALU: begin
        case (op_if.fn)
          5'b10000: res = sum;
          5'b10001: res = dif_is;
          5'b10010: res = dif_si;
          5'b10101: res = {1'b0, sa_q ^ idb_q};
          5'b10110: res = {1'b0, sa_q & idb_q};
          5'b10111: res = {1'b0, sa_q | idb_q};
          5'b11000: res = {1'b0, acc >> idb_q};
          5'b11001: res = {1'b0, asr};
          5'b11010: res = {1'b0, rot};
          default: res = {1'b0, acc << idb_q};  // 11011
        endcase
      end
      default: ;
    endcase
    new_flags.n = res[23];
    new_flags.z = (res[23:0] == '0);
    case (op_if.fn)
      5'b10000: new_flags.c = res[24];
      5'b10001, 5'b10010, 5'b01001, 5'b01010: new_flags.c = ~res[24];  // no borrow
      default: new_flags.c = flags.c;
    endcase
  end

  assign a_wr = (op_if.op == OP_LD && op_if.sub[1:0] == 2'b00)
             || op_if.op == OP_ALU || op_if.op == OP_SEX;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      ph1            <= 1'b0;
      wb_if.a_we     <= 1'b0;
      wb_if.flags_we <= 1'b0;
      wb_if.gpr_we   <= 1'b0;
    end else begin
      ph1            <= op_if.op_valid;
      wb_if.a_we     <= ph1 && a_wr;
      wb_if.flags_we <= ph1 && (op_if.op == OP_ALU || op_if.op == OP_CMP);
      wb_if.gpr_we   <= ph1 && op_if.op == OP_ST && op_if.param[7:4] == SEL_GPR[7:4];
    end
  end

  always_ff @(posedge CLK) begin
    if (op_if.op_valid) begin
      idb_q <= operand;
      sa_q  <= shifted;
    end
    if (ph1) begin
      wb_if.a_data   <= res[23:0];
      wb_if.flags    <= new_flags;
      wb_if.gpr_idx  <= op_if.param[3:0];
      wb_if.gpr_data <= acc;  // ST source
    end
  end

endmodule

//--- hdl/cx4_result.sv
`timescale 1ns/100ps

module cx4_result import cx4_pkg::*; (
  input  logic         CLK,
  input  logic         arst_n,
  cx4_wb_if.result     wb_if,
  input  cx4_gpr_idx_t gpr_rd_idx,
  input  logic [5:0]   ADDR,
  input  logic [7:0]   DI,
  input  logic         gpr_host_we,
  output cx4_word_t    acc,
  output cx4_flags_t   flags,
  output cx4_word_t    gpr_rd_data,
  output logic [7:0]   gpr_rd_byte
);

  logic [7:0] gpr [GPR_COUNT*3];  // byte view, low byte first
  logic [5:0] rd_base;
  logic [5:0] wr_base;

  assign rd_base = {2'b00, gpr_rd_idx} * 6'd3;
  assign wr_base = {2'b00, wb_if.gpr_idx} * 6'd3;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      acc   <= '0;
      flags <= '0;
      for (int i = 0; i < GPR_COUNT*3; i++) begin
        gpr[i] <= 8'h00;
      end
    end else begin
      if (wb_if.a_we) acc <= wb_if.a_data;
      if (wb_if.flags_we) flags <= wb_if.flags;
      if (wb_if.gpr_we) begin  // cpu wins over host
        gpr[wr_base]     <= wb_if.gpr_data[7:0];
        gpr[wr_base + 1] <= wb_if.gpr_data[15:8];
        gpr[wr_base + 2] <= wb_if.gpr_data[23:16];
      end else if (gpr_host_we) begin
        gpr[ADDR] <= DI;
      end
    end
  end

  assign gpr_rd_data = {gpr[rd_base + 2], gpr[rd_base + 1], gpr[rd_base]};

  // top quarter of the window is not backed
  assign gpr_rd_byte = (ADDR[5:4] == 2'b11) ? 8'h00 : gpr[ADDR];

endmodule

//--- hdl/cx4_top.sv
`timescale 1ns/100ps

module cx4_top import cx4_pkg::*; #(
  parameter int PGM_AW = 8
) (
  input  logic        CLK,
  input  logic        arst_n,
  input  logic        CS,
  input  logic [12:0] ADDR,
  input  logic [7:0]  DI,
  input  logic        reg_we_rising,
  output logic [7:0]  DO,
  output logic        cx4_active
);

  logic              go;
  logic              halt;
  logic [7:0]        start_pc;
  logic              pgm_we;
  logic              gpr_host_we;
  logic [7:0]        gpr_rd_byte;
  logic [PGM_AW-1:0] pgm_raddr;
  cx4_instr_t        instr;
  cx4_word_t         acc;
  cx4_flags_t        flags;
  cx4_gpr_idx_t      gpr_rd_idx;
  cx4_word_t         gpr_rd_data;

  cx4_op_if op_if ();
  cx4_wb_if wb_if ();

  //////////////////////////////////////////////////
  // host window
  //////////////////////////////////////////////////
  cx4_host_regs host_regs_i (
    .CLK, .arst_n, .CS, .ADDR, .DI, .reg_we_rising,
    .halt, .gpr_rd_byte, .DO, .go, .start_pc,
    .cx4_active, .pgm_we, .gpr_host_we
  );

  cx4_pgm_ram #(.PGM_AW(PGM_AW)) pgm_ram_i (
    .CLK, .we(pgm_we), .waddr(ADDR), .wdata(DI),
    .raddr(pgm_raddr), .rdata(instr)
  );

  //////////////////////////////////////////////////
  // cpu stages
  //////////////////////////////////////////////////
  cx4_decode #(.PGM_AW(PGM_AW)) decode_i (
    .CLK, .arst_n, .go, .start_pc, .instr, .flags,
    .pgm_raddr, .halt, .op_if(op_if.decode)
  );

  cx4_execute execute_i (
    .CLK, .arst_n, .op_if(op_if.execute), .acc, .flags,
    .gpr_rd_data, .gpr_rd_idx, .wb_if(wb_if.execute)
  );

  cx4_result result_i (
    .CLK, .arst_n, .wb_if(wb_if.result), .gpr_rd_idx,
    .ADDR(ADDR[5:0]), .DI, .gpr_host_we,
    .acc, .flags, .gpr_rd_data, .gpr_rd_byte
  );

endmodule

//--- dv/cx4_tb.sv
`timescale 1ns/100ps

module cx4_tb import cx4_pkg::*; ();

  localparam int CLK_PERIOD  = 40;
  localparam int TEST_COUNT  = 6;
  localparam int TEST_CYCLES = 2000;   // budget per test
  localparam int LOOP_START  = 7;
  localparam int LOOP_STOP   = 3;

  logic        CLK;
  logic        arst_n;
  logic        CS;
  logic [12:0] ADDR;
  logic [7:0]  DI;
  logic        reg_we_rising;
  logic [7:0]  DO;
  logic        cx4_active;
  cx4_instr_t  prog [$];               // words for the next load
  integer      seed;

  cx4_top #(.PGM_AW(8)) cx4_top_i (
    .CLK, .arst_n, .CS, .ADDR, .DI, .reg_we_rising, .DO, .cx4_active
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD/2) CLK = ~CLK;
  end

  initial begin
    #(TEST_COUNT*TEST_CYCLES*CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the tests did not finish",
             TEST_COUNT*TEST_CYCLES);
    $display("Simulation failed");
    $fatal(1, "timeout");
  end

  //////////////////////////////////////////////////
  // host bus and compare tasks
  //////////////////////////////////////////////////
  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) fail_now($sformatf("error %s: expected %02h, actual %02h", name, exp, act));
  endtask

  task automatic check_word(input string name, input cx4_word_t exp, input cx4_word_t act);
    if (act !== exp) fail_now($sformatf("error %s: expected %06h, actual %06h", name, exp, act));
  endtask

  task automatic host_write(input logic [12:0] addr, input logic [7:0] data);
    @(negedge CLK);
    CS            = 1'b1;
    ADDR          = addr;
    DI            = data;
    reg_we_rising = 1'b1;                // one cycle strobe
    @(negedge CLK);
    reg_we_rising = 1'b0;
    CS            = 1'b0;
  endtask

  task automatic host_read(input logic [12:0] addr, output logic [7:0] data);
    @(negedge CLK);
    CS   = 1'b1;
    ADDR = addr;
    @(negedge CLK);
    data = DO;                           // settled a full cycle
    CS   = 1'b0;
  endtask

  task automatic write_gpr(input int idx, input cx4_word_t value);
    for (int b = 0; b < 3; b++) host_write(GPR_BASE + 13'(idx*3 + b), value[8*b +: 8]);
  endtask

  task automatic check_gpr(input string name, input int idx, input cx4_word_t exp);
    cx4_word_t  value;
    logic [7:0] data;
    for (int b = 0; b < 3; b++) begin
      host_read(GPR_BASE + 13'(idx*3 + b), data);
      value[8*b +: 8] = data;            // low byte first
    end
    check_word(name, exp, value);
  endtask

  task automatic load_program();
    foreach (prog[i]) begin
      host_write(PGM_BASE + 13'(2*i), prog[i][7:0]);
      host_write(PGM_BASE + 13'(2*i + 1), prog[i][15:8]);
    end
    prog.delete();
  endtask

  task automatic run_until_idle(input string name);
    int cycles;
    cycles = 0;
    while (cx4_active) begin
      @(negedge CLK);
      cycles++;
      if (cycles > TEST_CYCLES) fail_now($sformatf("%s: the program never halted", name));
    end
  endtask

  task automatic run_program(input string name);
    logic [7:0] data;
    load_program();
    host_write(MMIO_PC_ADDR, 8'h00);     // start at word 0
    check_byte({name, " active"}, 8'h01, {7'b0, cx4_active});
    host_read(STATUS_BASE, data);
    check_byte({name, " busy status"}, 8'h40, data);
    run_until_idle(name);
    host_read(STATUS_BASE, data);
    check_byte({name, " idle status"}, 8'h02, data);
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////
  task automatic reset_values();
    logic [7:0] data;
    host_read(STATUS_BASE, data);
    check_byte("reset status", 8'h02, data);
    check_byte("reset active", 8'h00, {7'b0, cx4_active});
    for (int i = 0; i < GPR_COUNT*3; i++) begin
      host_read(GPR_BASE + 13'(i), data);
      check_byte("reset gpr byte", 8'h00, data);
    end
  endtask

  task automatic host_gpr_access();
    logic [7:0] data;
    for (int i = 30; i < 36; i++) host_write(13'h1fc0 + 13'(i), 8'(i*37 + 5));  // r10, r11
    for (int i = 30; i < 36; i++) begin
      host_read(GPR_BASE + 13'(i), data);
      check_byte("gpr via mirror", 8'(i*37 + 5), data);
      host_read(13'h1fc0 + 13'(i), data);
      check_byte("gpr mirror read", 8'(i*37 + 5), data);
    end
    write_gpr(12, 24'h89abcd);
    check_gpr("gpr word", 12, 24'h89abcd);
  endtask

  task automatic add_and_store();
    write_gpr(12, 24'hffff80);
    prog = {16'h64c5, 16'h806c, 16'he06d, 16'hf800};  // ld, add r12, st r13, hlt
    run_program("add program");
    check_gpr("add program sum", 13, cx4_word_t'(24'hffff80 + 24'h0000c5));
  endtask

  task automatic alu_with_shifts();
    cx4_word_t a;
    cx4_word_t exp [9];
    a = 24'h00005a;
    a = (a << 1) ^ CX4_CONST[4];
    exp[0] = a;
    a = (a << 8) & CX4_CONST[5];
    exp[1] = a;
    a = (a << 16) | CX4_CONST[2];
    exp[2] = a;
    a = 24'h000081;
    a = {{16{a[7]}}, a[7:0]};            // byte sign extension
    exp[3] = a;
    a = a >> 4;
    exp[4] = a;
    a = CX4_CONST[6];
    a = {{8{a[23]}}, a[23:8]};           // arithmetic shift right by 8
    exp[5] = a;
    a = {a[3:0], a[23:4]};               // rotate right by 4
    exp[6] = a;
    exp[7] = a << 12;
    exp[8] = {{8{exp[6][15]}}, exp[6][15:0]};
    prog = {16'h645a, 16'ha954, 16'he060, 16'hb255, 16'he061, 16'hbb52, 16'he062,
            16'h6481, 16'h5900, 16'he063, 16'hc404, 16'he064, 16'h6056, 16'hcc08,
            16'he065, 16'hd404, 16'he066, 16'hdc0c, 16'he067, 16'h5a66, 16'he068,
            16'hf800};
    run_program("alu ops");
    for (int i = 0; i < 9; i++) check_gpr($sformatf("alu ops r%0d", i), i, exp[i]);
  endtask

  task automatic countdown_loop();
    write_gpr(2, 24'h123456);            // only reached if the skip fails
    prog = {16'h6400, 16'he061, 16'h6400 | 16'(LOOP_START), 16'he060,
            16'h6061, 16'h8401, 16'he061, 16'h6060, 16'h9401, 16'he060,
            16'h5400 | 16'(LOOP_STOP), 16'h0c0d, 16'h0804, 16'h2101, 16'he062, 16'hf800};
    run_program("countdown");
    check_gpr("countdown count", 1, cx4_word_t'(LOOP_START - LOOP_STOP));
    check_gpr("countdown end", 0, cx4_word_t'(LOOP_STOP));
    check_gpr("countdown skip", 2, 24'h123456);
  endtask

  task automatic random_arith();
    cx4_word_t a;
    cx4_word_t b;
    for (int r = 0; r < 3; r++) begin
      a = cx4_word_t'($random(seed));
      b = cx4_word_t'($random(seed));
      write_gpr(4, a);
      write_gpr(5, b);
      prog = {16'h6064, 16'h8065, 16'he066, 16'h6064, 16'h8865, 16'he067,
              16'h6064, 16'h9065, 16'he068, 16'h6064, 16'ha865, 16'he069, 16'hf800};
      run_program("random ops");
      check_gpr("random add", 6, cx4_word_t'(a + b));
      check_gpr("random sub operand minus a", 7, cx4_word_t'(b - a));
      check_gpr("random sub a minus operand", 8, cx4_word_t'(a - b));
      check_gpr("random xor", 9, a ^ b);
    end
  endtask

  initial begin
    seed          = 85;
    arst_n        = 1'b0;
    CS            = 1'b0;
    ADDR          = '0;
    DI            = '0;
    reg_we_rising = 1'b0;
    repeat (16) @(posedge CLK);
    @(negedge CLK);
    arst_n = 1'b1;
    reset_values();
    host_gpr_access();
    add_and_store();
    alu_with_shifts();
    countdown_loop();
    random_arith();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- cx4_top.f
hdl/cx4_pkg.sv
hdl/cx4_op_if.sv
hdl/cx4_wb_if.sv
hdl/cx4_host_regs.sv
hdl/cx4_pgm_ram.sv
hdl/cx4_decode.sv
hdl/cx4_execute.sv
hdl/cx4_result.sv
hdl/cx4_top.sv
dv/cx4_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = cx4_tb
RTL_TOP  = cx4_top
FILELIST = cx4_top.f
PASS_MSG = Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
